/* dd_pkg.sv */
package dd_pkg;

    localparam int data_w       = 32;
    localparam int addr_w       = 9;
    localparam int sector_sel   = 8;   // address bit that selects the sector buffer.
    localparam int sector_words = 64;
    localparam int sector_aw    = 6;

    localparam int cmd_w        = 8;
    localparam int cmd_data_w   = 16;
    localparam int head_track_w = 14;
    localparam int drive_id_w   = 16;
    localparam int reg_idx_w    = 3;

    // register indices come from address bits 4 to 2.
    localparam logic [reg_idx_w-1:0] reg_scr         = 3'd0;
    localparam logic [reg_idx_w-1:0] reg_cmd_data    = 3'd1;
    localparam logic [reg_idx_w-1:0] reg_head_track  = 3'd2;
    localparam logic [reg_idx_w-1:0] reg_sector_info = 3'd3;
    localparam logic [reg_idx_w-1:0] reg_drive_id    = 3'd4;
    localparam logic [reg_idx_w-1:0] reg_seek_timer  = 3'd5;

    localparam int scr_hard_reset       = 0;
    localparam int scr_hard_reset_clear = 1;
    localparam int scr_cmd_pending      = 2;
    localparam int scr_cmd_ready        = 3;
    localparam int scr_bm_pending       = 4;
    localparam int scr_bm_ready         = 5;
    localparam int scr_disk_inserted    = 6;
    localparam int scr_disk_changed     = 7;
    localparam int scr_bm_start_pending = 8;
    localparam int scr_bm_start_clear   = 9;
    localparam int scr_bm_stop_pending  = 10;
    localparam int scr_bm_stop_clear    = 11;
    localparam int scr_bm_ack           = 16;
    localparam int scr_bm_ack_clear     = 18;
    localparam int scr_bm_clear         = 19;
    localparam int scr_seek_clear       = 20;

    typedef enum logic [1:0] {
        idle,
        cmd_wait,
        reset_hold
    } drive_state_t;

endpackage

/* dd_regs_if.sv */
`timescale 1ns/1ps

interface dd_regs_if import dd_pkg::*; ();

    logic [cmd_w-1:0]      cmd;
    logic [cmd_data_w-1:0] data;
    logic [cmd_data_w-1:0] cmd_data;

    logic hard_reset;
    logic cmd_pending;
    logic bm_pending;
    logic bm_start_pending;
    logic bm_stop_pending;

    // single-cycle strobes.
    logic hard_reset_clear;
    logic cmd_ready;
    logic bm_ready;
    logic bm_start_clear;
    logic bm_stop_clear;
    logic bm_clear;
    logic bm_interrupt_ack;

    logic [sector_aw-1:0] sector_address;
    logic                 sector_write;
    logic [data_w-1:0]    sector_wdata;
    logic [data_w-1:0]    sector_rdata;

    modport regs (
        input  cmd, data, hard_reset, cmd_pending, bm_pending, bm_start_pending,
        input  bm_stop_pending, bm_interrupt_ack, sector_rdata,
        output cmd_data, hard_reset_clear, cmd_ready, bm_ready, bm_start_clear,
        output bm_stop_clear, bm_clear, sector_address, sector_write, sector_wdata
    );

    modport drive (
        input  cmd_data, hard_reset_clear, cmd_ready, bm_ready, bm_start_clear,
        input  bm_stop_clear, bm_clear,
        output cmd, data, hard_reset, cmd_pending, bm_pending, bm_start_pending,
        output bm_stop_pending, bm_interrupt_ack
    );

    modport buffer (
        input  sector_address, sector_write, sector_wdata,
        output sector_rdata
    );

endinterface

/* dd_cpu_regs.sv */
`timescale 1ns/1ps

module dd_cpu_regs import dd_pkg::*; (
    input  logic              sys,
    input  logic              rst_n,
    input  logic              request,
    input  logic [addr_w-1:0] address,
    input  logic [3:0]        wmask,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              ack,
    dd_regs_if.regs           regs,
    output logic              seek_clear,
    input  logic [data_w-1:0] seek_count,
    output logic              disk_inserted,
    output logic              disk_changed
);

    logic [head_track_w-1:0] head_track;
    logic [drive_id_w-1:0]   drive_id;
    logic                    bm_ack;
    logic                    buf_sel;
    logic                    reg_write;
    logic [reg_idx_w-1:0]    reg_idx;
    logic [data_w-1:0]       scr_value;
    logic [data_w-1:0]       reg_value;
    logic [data_w-1:0]       reg_rdata;
    logic                    buf_sel_q;

    function automatic logic [data_w-1:0] byte_swap(input logic [data_w-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign buf_sel   = address[sector_sel];
    assign reg_idx   = address[4:2];
    assign reg_write = request && !buf_sel;

    // the buffer stores words in host byte order.
    assign regs.sector_address = address[sector_aw+1:2];
    assign regs.sector_write   = request && buf_sel && (&wmask);
    assign regs.sector_wdata   = byte_swap(wdata);

    always_comb begin
        scr_value = '0;
        scr_value[scr_hard_reset]       = regs.hard_reset;
        scr_value[scr_cmd_pending]      = regs.cmd_pending;
        scr_value[scr_bm_pending]       = regs.bm_pending;
        scr_value[scr_disk_inserted]    = disk_inserted;
        scr_value[scr_disk_changed]     = disk_changed;
        scr_value[scr_bm_start_pending] = regs.bm_start_pending;
        scr_value[scr_bm_stop_pending]  = regs.bm_stop_pending;
        scr_value[scr_bm_ack]           = bm_ack;
    end

    always_comb begin
        case (reg_idx)
            reg_scr:         reg_value = scr_value;
            reg_cmd_data:    reg_value = {8'd0, regs.cmd, regs.data};
            reg_head_track:  reg_value = data_w'(head_track);
            reg_sector_info: reg_value = '0;   // sector geometry is not kept here.
            reg_drive_id:    reg_value = data_w'(drive_id);
            reg_seek_timer:  reg_value = seek_count;
            default:         reg_value = '0;
        endcase
    end

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            ack                   <= 1'b0;
            regs.hard_reset_clear <= 1'b0;
            regs.cmd_ready        <= 1'b0;
            regs.bm_ready         <= 1'b0;
            regs.bm_start_clear   <= 1'b0;
            regs.bm_stop_clear    <= 1'b0;
            regs.bm_clear         <= 1'b0;
            seek_clear            <= 1'b0;
            disk_inserted         <= 1'b0;
            disk_changed          <= 1'b0;
            bm_ack                <= 1'b0;
            head_track            <= '0;
            drive_id              <= '0;
            regs.cmd_data         <= '0;
        end else begin
            ack                   <= request;
            regs.hard_reset_clear <= 1'b0;
            regs.cmd_ready        <= 1'b0;
            regs.bm_ready         <= 1'b0;
            regs.bm_start_clear   <= 1'b0;
            regs.bm_stop_clear    <= 1'b0;
            regs.bm_clear         <= 1'b0;
            seek_clear            <= 1'b0;
            if (regs.bm_interrupt_ack) begin
                bm_ack <= 1'b1;
            end
            if (reg_write) begin
                case (reg_idx)
                    reg_scr: if (&wmask) begin
                        regs.hard_reset_clear <= wdata[scr_hard_reset_clear];
                        regs.cmd_ready        <= wdata[scr_cmd_ready];
                        regs.bm_ready         <= wdata[scr_bm_ready];
                        regs.bm_start_clear   <= wdata[scr_bm_start_clear];
                        regs.bm_stop_clear    <= wdata[scr_bm_stop_clear];
                        regs.bm_clear         <= wdata[scr_bm_clear];
                        seek_clear            <= wdata[scr_seek_clear];
                        disk_inserted         <= wdata[scr_disk_inserted];
                        disk_changed          <= wdata[scr_disk_changed];
                        if (wdata[scr_bm_ack_clear]) begin
                            bm_ack <= 1'b0;   // a clear wins over a new ack.
                        end
                    end
                    reg_cmd_data: if (&wmask[1:0]) begin
                        regs.cmd_data <= wdata[cmd_data_w-1:0];
                    end
                    reg_head_track: if (&wmask[1:0]) begin
                        head_track <= wdata[head_track_w-1:0];
                    end
                    reg_drive_id: if (&wmask[1:0]) begin
                        drive_id <= wdata[drive_id_w-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data is captured with the request and shown during ack.
    always_ff @(posedge sys) begin
        if (request) begin
            buf_sel_q <= buf_sel;
            reg_rdata <= reg_value;
        end
    end

    assign rdata = !ack ? '0 : (buf_sel_q ? byte_swap(regs.sector_rdata) : reg_rdata);

    ack_follows_request: assert property (
        @(posedge sys) disable iff (!rst_n) ack |-> $past(request)
    ) else $error("ack without a request in the previous cycle");

endmodule

/* dd_drive_fsm.sv */
`timescale 1ns/1ps

module dd_drive_fsm import dd_pkg::*; (
    input  logic                  sys,
    input  logic                  rst_n,
    input  logic                  host_cmd_valid,
    input  logic [cmd_w-1:0]      host_cmd,
    input  logic [cmd_data_w-1:0] host_data,
    input  logic                  host_hard_reset,
    input  logic                  host_bm_start,
    input  logic                  host_bm_stop,
    input  logic                  host_bm_interrupt_ack,
    output logic                  host_cmd_done,
    output logic [cmd_data_w-1:0] host_resp_data,
    output logic                  host_bm_ready,
    dd_regs_if.drive              regs
);

    drive_state_t state;

    assign regs.bm_interrupt_ack = host_bm_interrupt_ack;

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            state                 <= idle;
            regs.cmd              <= '0;
            regs.data             <= '0;
            regs.hard_reset       <= 1'b0;
            regs.cmd_pending      <= 1'b0;
            regs.bm_pending       <= 1'b0;
            regs.bm_start_pending <= 1'b0;
            regs.bm_stop_pending  <= 1'b0;
            host_cmd_done         <= 1'b0;
            host_bm_ready         <= 1'b0;
        end else begin
            host_cmd_done <= 1'b0;
            host_bm_ready <= 1'b0;
            case (state)
                idle: if (host_cmd_valid) begin
                    regs.cmd         <= host_cmd;
                    regs.data        <= host_data;
                    regs.cmd_pending <= 1'b1;
                    state            <= cmd_wait;
                end
                cmd_wait: if (regs.cmd_ready) begin
                    host_cmd_done    <= 1'b1;
                    regs.cmd_pending <= 1'b0;
                    state            <= idle;
                end
                reset_hold: if (regs.hard_reset_clear) begin
                    regs.hard_reset <= 1'b0;
                    state           <= idle;
                end
                default: state <= idle;
            endcase

            // a hard reset aborts whatever command is in flight.
            if (host_hard_reset) begin
                regs.hard_reset  <= 1'b1;
                regs.cmd_pending <= 1'b0;
                host_cmd_done    <= 1'b0;
                state            <= reset_hold;
            end

            if (regs.bm_ready) begin
                host_bm_ready   <= 1'b1;
                regs.bm_pending <= 1'b0;
            end
            if (regs.bm_clear) begin
                regs.bm_pending <= 1'b0;
            end
            if (regs.bm_start_clear) begin
                regs.bm_start_pending <= 1'b0;
            end
            if (regs.bm_stop_clear) begin
                regs.bm_stop_pending <= 1'b0;
            end
            if (host_bm_start) begin
                regs.bm_pending       <= 1'b1;   // new host requests win over clears.
                regs.bm_start_pending <= 1'b1;
            end
            if (host_bm_stop) begin
                regs.bm_stop_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys) begin
        if (state == cmd_wait && regs.cmd_ready) begin
            host_resp_data <= regs.cmd_data;
        end
    end

    pending_in_cmd_wait: assert property (
        @(posedge sys) disable iff (!rst_n) regs.cmd_pending == (state == cmd_wait)
    ) else $error("cmd_pending out of step with the command state");

    cmd_only_when_idle: assert property (
        @(posedge sys) disable iff (!rst_n) host_cmd_valid |-> state == idle
    ) else $warning("host command dropped while busy");

endmodule

/* dd_seek_timer.sv */
`timescale 1ns/1ps

module dd_seek_timer import dd_pkg::*; (
    input  logic              sys,
    input  logic              rst_n,
    input  logic              clear,
    output logic [data_w-1:0] count
);

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (!(&count)) begin
            count <= count + 1'b1;   // holds once every bit is set.
        end
    end

    no_wrap: assert property (
        @(posedge sys) disable iff (!rst_n) (&count) && !clear |=> &count
    ) else $error("seek timer wrapped");

endmodule

/* dd_sector_buffer.sv */
`timescale 1ns/1ps

module dd_sector_buffer import dd_pkg::*; (
    input  logic                 sys,
    dd_regs_if.buffer            port,
    input  logic [sector_aw-1:0] host_address,
    output logic [data_w-1:0]    host_rdata
);

    logic [data_w-1:0] mem [sector_words];

    // the cpu port read returns the old word on a same-cycle write.
    always_ff @(posedge sys) begin
        if (port.sector_write) begin
            mem[port.sector_address] <= port.sector_wdata;
        end
        port.sector_rdata <= mem[port.sector_address];
    end

    always_ff @(posedge sys) begin
        host_rdata <= mem[host_address];
    end

endmodule

/* dd_top.sv */
`timescale 1ns/1ps

module dd_top import dd_pkg::*; (
    input  logic                  sys,
    input  logic                  rst_n,
    input  logic                  request,
    input  logic [addr_w-1:0]     address,
    input  logic [3:0]            wmask,
    input  logic [data_w-1:0]     wdata,
    output logic [data_w-1:0]     rdata,
    output logic                  ack,
    input  logic                  host_cmd_valid,
    input  logic [cmd_w-1:0]      host_cmd,
    input  logic [cmd_data_w-1:0] host_data,
    input  logic                  host_hard_reset,
    input  logic                  host_bm_start,
    input  logic                  host_bm_stop,
    input  logic                  host_bm_interrupt_ack,
    output logic                  host_cmd_done,
    output logic [cmd_data_w-1:0] host_resp_data,
    output logic                  host_bm_ready,
    output logic                  host_disk_inserted,
    output logic                  host_disk_changed,
    input  logic [sector_aw-1:0]  host_sector_address,
    output logic [data_w-1:0]     host_sector_rdata
);

    logic              seek_clear;
    logic [data_w-1:0] seek_count;

    dd_regs_if regs ();

    dd_cpu_regs u_cpu_regs (
        .sys           (sys),
        .rst_n         (rst_n),
        .request       (request),
        .address       (address),
        .wmask         (wmask),
        .wdata         (wdata),
        .rdata         (rdata),
        .ack           (ack),
        .regs          (regs.regs),
        .seek_clear    (seek_clear),
        .seek_count    (seek_count),
        .disk_inserted (host_disk_inserted),
        .disk_changed  (host_disk_changed)
    );

    dd_drive_fsm u_drive_fsm (
        .sys                   (sys),
        .rst_n                 (rst_n),
        .host_cmd_valid        (host_cmd_valid),
        .host_cmd              (host_cmd),
        .host_data             (host_data),
        .host_hard_reset       (host_hard_reset),
        .host_bm_start         (host_bm_start),
        .host_bm_stop          (host_bm_stop),
        .host_bm_interrupt_ack (host_bm_interrupt_ack),
        .host_cmd_done         (host_cmd_done),
        .host_resp_data        (host_resp_data),
        .host_bm_ready         (host_bm_ready),
        .regs                  (regs.drive)
    );

    dd_seek_timer u_seek_timer (
        .sys   (sys),
        .rst_n (rst_n),
        .clear (seek_clear),
        .count (seek_count)
    );

    dd_sector_buffer u_sector_buffer (
        .sys          (sys),
        .port         (regs.buffer),
        .host_address (host_sector_address),
        .host_rdata   (host_sector_rdata)
    );

endmodule

/* tb_dd.sv */
`timescale 1ns/1ps

module tb_dd import dd_pkg::*; ();

    localparam int timeout_cycles   = 4000;   // the directed tests need well under a thousand.
    localparam int pulse_hard_reset = 0;
    localparam int pulse_bm_start   = 1;
    localparam int pulse_bm_stop    = 2;
    localparam int pulse_irq_ack    = 3;

    logic                  sys;
    logic                  rst_n;
    logic                  request;
    logic [addr_w-1:0]     address;
    logic [3:0]            wmask;
    logic [data_w-1:0]     wdata;
    logic [data_w-1:0]     rdata;
    logic                  ack;
    logic                  host_cmd_valid;
    logic [cmd_w-1:0]      host_cmd;
    logic [cmd_data_w-1:0] host_data;
    logic                  host_hard_reset;
    logic                  host_bm_start;
    logic                  host_bm_stop;
    logic                  host_bm_interrupt_ack;
    logic                  host_cmd_done;
    logic [cmd_data_w-1:0] host_resp_data;
    logic                  host_bm_ready;
    logic                  host_disk_inserted;
    logic                  host_disk_changed;
    logic [sector_aw-1:0]  host_sector_address;
    logic [data_w-1:0]     host_sector_rdata;

    integer seed;
    int     cycle = 0;
    int     last_request_cycle;

    dd_top DUT (
        .sys                   (sys),
        .rst_n                 (rst_n),
        .request               (request),
        .address               (address),
        .wmask                 (wmask),
        .wdata                 (wdata),
        .rdata                 (rdata),
        .ack                   (ack),
        .host_cmd_valid        (host_cmd_valid),
        .host_cmd              (host_cmd),
        .host_data             (host_data),
        .host_hard_reset       (host_hard_reset),
        .host_bm_start         (host_bm_start),
        .host_bm_stop          (host_bm_stop),
        .host_bm_interrupt_ack (host_bm_interrupt_ack),
        .host_cmd_done         (host_cmd_done),
        .host_resp_data        (host_resp_data),
        .host_bm_ready         (host_bm_ready),
        .host_disk_inserted    (host_disk_inserted),
        .host_disk_changed     (host_disk_changed),
        .host_sector_address   (host_sector_address),
        .host_sector_rdata     (host_sector_rdata)
    );

    initial sys = 1'b0;
    always #10 sys = ~sys;

    always @(posedge sys) begin
        cycle <= cycle + 1;
    end

    initial begin
        repeat (timeout_cycles) @(posedge sys);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [addr_w-1:0] reg_addr(input logic [reg_idx_w-1:0] idx);
        return {4'b0000, idx, 2'b00};
    endfunction

    function automatic logic [addr_w-1:0] sector_addr(input logic [sector_aw-1:0] slot);
        return {1'b1, slot, 2'b00};   // bit 8 picks the buffer.
    endfunction

    function automatic logic [data_w-1:0] scr_bit(input int pos);
        return 32'd1 << pos;
    endfunction

    function automatic logic [data_w-1:0] reverse_bytes(input logic [data_w-1:0] w);
        logic [data_w-1:0] r;
        int b;
        for (b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic bus_write(input logic [addr_w-1:0] addr, input logic [3:0] mask,
                             input logic [data_w-1:0] data);
        @(posedge sys);
        #1;
        request = 1'b1;
        address = addr;
        wmask = mask;
        wdata = data;
        last_request_cycle = cycle;
        @(posedge sys);
        #1;
        request = 1'b0;
        check("write ack", 1, ack);   // one cycle after the request.
    endtask

    task automatic bus_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
        @(posedge sys);
        #1;
        request = 1'b1;
        address = addr;
        wmask = 4'h0;
        last_request_cycle = cycle;
        @(posedge sys);
        #1;
        request = 1'b0;
        check("read ack", 1, ack);
        data = rdata;
    endtask

    task automatic host_sector_read(input logic [sector_aw-1:0] slot,
                                    output logic [data_w-1:0] data);
        @(posedge sys);
        #1;
        host_sector_address = slot;
        @(posedge sys);
        #1;
        data = host_sector_rdata;
    endtask

    task automatic host_pulse(input int sel);
        @(posedge sys);
        #1;
        case (sel)
            pulse_hard_reset: host_hard_reset = 1'b1;
            pulse_bm_start:   host_bm_start = 1'b1;
            pulse_bm_stop:    host_bm_stop = 1'b1;
            default:          host_bm_interrupt_ack = 1'b1;
        endcase
        @(posedge sys);
        #1;
        host_hard_reset = 1'b0;
        host_bm_start = 1'b0;
        host_bm_stop = 1'b0;
        host_bm_interrupt_ack = 1'b0;
    endtask

    // the host strobe must be high only in the second cycle after the request cycle.
    task automatic write_and_time_pulse(input string name, input logic [data_w-1:0] data,
                                        input bit use_bm_ready);
        logic level;
        int k;
        bus_write(reg_addr(reg_scr), 4'hf, data);
        for (k = 1; k <= 3; k++) begin
            if (k > 1) begin
                @(posedge sys);
                #1;
            end
            level = use_bm_ready ? host_bm_ready : host_cmd_done;
            check(name, (k == 2), level);
        end
    endtask

    task automatic reset_state_test();
        logic [data_w-1:0] value;
        check("reset cmd_done", 0, host_cmd_done);
        check("reset bm_ready", 0, host_bm_ready);
        check("reset disk_inserted", 0, host_disk_inserted);
        check("reset disk_changed", 0, host_disk_changed);
        bus_read(reg_addr(reg_scr), value);
        check("reset scr", 0, value);
        bus_read(reg_addr(reg_cmd_data), value);
        check("reset cmd_data", 0, value);
        bus_read(reg_addr(reg_head_track), value);
        check("reset head_track", 0, value);
        bus_read(reg_addr(reg_drive_id), value);
        check("reset drive_id", 0, value);
    endtask

    task automatic register_readback_test();
        logic [data_w-1:0] value;
        logic [data_w-1:0] track;
        logic [data_w-1:0] id;
        track = $random(seed);
        id = $random(seed);
        bus_write(reg_addr(reg_head_track), 4'hf, track);
        bus_read(reg_addr(reg_head_track), value);
        check("head_track readback", {18'd0, track[13:0]}, value);
        bus_write(reg_addr(reg_drive_id), 4'hf, id);
        bus_read(reg_addr(reg_drive_id), value);
        check("drive_id readback", {16'd0, id[15:0]}, value);
        bus_write(reg_addr(reg_head_track), 4'b1110, ~track);
        bus_write(reg_addr(reg_drive_id), 4'b0001, ~id);
        bus_read(reg_addr(reg_head_track), value);
        check("head_track partial mask", {18'd0, track[13:0]}, value);
        bus_read(reg_addr(reg_drive_id), value);
        check("drive_id partial mask", {16'd0, id[15:0]}, value);
        bus_write(reg_addr(reg_scr), 4'hf, scr_bit(scr_disk_inserted) | scr_bit(scr_disk_changed));
        check("disk_inserted level", 1, host_disk_inserted);
        check("disk_changed level", 1, host_disk_changed);
        bus_read(reg_addr(reg_scr), value);
        check("disk bits readback", 32'h0000_00c0, value);
        bus_write(reg_addr(reg_scr), 4'hf, 32'h0);
        check("disk_inserted cleared", 0, host_disk_inserted);
        check("disk_changed cleared", 0, host_disk_changed);
    endtask

    task automatic sector_buffer_test();
        logic [sector_aw-1:0] slots [4];
        logic [data_w-1:0]    words [4];
        logic [data_w-1:0]    value;
        int i;
        slots = '{6'd0, 6'd9, 6'd33, 6'd63};
        for (i = 0; i < 4; i++) begin
            words[i] = $random(seed);
            bus_write(sector_addr(slots[i]), 4'hf, words[i]);
        end
        for (i = 0; i < 4; i++) begin
            bus_read(sector_addr(slots[i]), value);
            check("sector cpu readback", words[i], value);
            host_sector_read(slots[i], value);
            check("sector host read", reverse_bytes(words[i]), value);
        end
    endtask

    task automatic command_exchange_test();
        logic [data_w-1:0] value;
        logic [data_w-1:0] stim;
        logic [data_w-1:0] resp;
        stim = $random(seed);
        resp = $random(seed);
        @(posedge sys);
        #1;
        host_cmd_valid = 1'b1;
        host_cmd = stim[31:24];
        host_data = stim[15:0];
        @(posedge sys);
        #1;
        host_cmd_valid = 1'b0;
        bus_read(reg_addr(reg_scr), value);
        check("cmd_pending set", scr_bit(scr_cmd_pending), value);
        bus_read(reg_addr(reg_cmd_data), value);
        check("cmd_data readback", {8'd0, stim[31:24], stim[15:0]}, value);
        bus_write(reg_addr(reg_cmd_data), 4'hf, resp);
        write_and_time_pulse("cmd_done timing", scr_bit(scr_cmd_ready), 1'b0);
        check("response data", {16'd0, resp[15:0]}, host_resp_data);
        bus_read(reg_addr(reg_scr), value);
        check("cmd_pending cleared", 0, value);
    endtask

    task automatic hard_reset_and_bm_test();
        logic [data_w-1:0] value;
        host_pulse(pulse_hard_reset);
        bus_read(reg_addr(reg_scr), value);
        check("hard_reset set", scr_bit(scr_hard_reset), value);
        bus_write(reg_addr(reg_scr), 4'hf, scr_bit(scr_hard_reset_clear));
        bus_read(reg_addr(reg_scr), value);
        check("hard_reset cleared", 0, value);
        host_pulse(pulse_bm_start);
        host_pulse(pulse_bm_stop);
        bus_read(reg_addr(reg_scr), value);
        check("bm start and stop", scr_bit(scr_bm_pending) | scr_bit(scr_bm_start_pending)
              | scr_bit(scr_bm_stop_pending), value);
        bus_write(reg_addr(reg_scr), 4'hf, scr_bit(scr_bm_start_clear));
        bus_read(reg_addr(reg_scr), value);
        check("bm start clear", scr_bit(scr_bm_pending) | scr_bit(scr_bm_stop_pending), value);
        bus_write(reg_addr(reg_scr), 4'hf, scr_bit(scr_bm_stop_clear));
        bus_read(reg_addr(reg_scr), value);
        check("bm stop clear", scr_bit(scr_bm_pending), value);
        write_and_time_pulse("bm_ready timing", scr_bit(scr_bm_ready), 1'b1);
        bus_read(reg_addr(reg_scr), value);
        check("bm_pending cleared", 0, value);
        host_pulse(pulse_irq_ack);
        bus_read(reg_addr(reg_scr), value);
        check("bm_ack set", scr_bit(scr_bm_ack), value);
        bus_write(reg_addr(reg_scr), 4'hf, scr_bit(scr_bm_ack_clear));
        bus_read(reg_addr(reg_scr), value);
        check("bm_ack cleared", 0, value);
    endtask

    task automatic seek_timer_test();
        logic [data_w-1:0] first;
        logic [data_w-1:0] second;
        int first_cycle;
        int gap;
        gap = 3 + ($random(seed) & 7);
        bus_write(reg_addr(reg_scr), 4'hf, scr_bit(scr_seek_clear));
        bus_read(reg_addr(reg_seek_timer), first);
        first_cycle = last_request_cycle;
        repeat (gap) @(posedge sys);
        bus_read(reg_addr(reg_seek_timer), second);
        check("seek first below 100", 1, first < 100);
        check("seek second below 100", 1, second < 100);
        check("seek count step", last_request_cycle - first_cycle, second - first);
    endtask

    initial begin
        seed = 38;
        rst_n = 1'b0;
        request = 1'b0;
        address = '0;
        wmask = '0;
        wdata = '0;
        host_cmd_valid = 1'b0;
        host_cmd = '0;
        host_data = '0;
        host_hard_reset = 1'b0;
        host_bm_start = 1'b0;
        host_bm_stop = 1'b0;
        host_bm_interrupt_ack = 1'b0;
        host_sector_address = '0;
        repeat (5) @(posedge sys);
        #1;
        rst_n = 1'b1;
        reset_state_test();
        register_readback_test();
        sector_buffer_test();
        command_exchange_test();
        hard_reset_and_bm_test();
        seek_timer_test();
        $display("test passed");
        $finish;
    end

endmodule

/* all.f */
dd_pkg.sv
dd_regs_if.sv
dd_cpu_regs.sv
dd_drive_fsm.sv
dd_seek_timer.sv
dd_sector_buffer.sv
dd_top.sv
tb_dd.sv

/* run.sh */
#!/bin/bash
# build and run the register-side simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_dd -o tb_dd_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_dd_sim > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
